//--- Bender.yml
package:
  name: ex_stage

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/ex_data_pkg.sv
      - hdl/ex_ctrl_pkg.sv
      - hdl/ex_issue_reg.sv
      - hdl/ex_alu.sv
      - hdl/ex_branch_unit.sv
      - hdl/ex_mul_unit.sv
      - hdl/ex_result_stage.sv
      - hdl/ex_stage.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - verif/ex_stage_tb.sv

//--- hdl/ex_alu.sv
`include "ex_consts.svh"

module ex_alu (
    input  ex_data_pkg::xword_t  src1,
    input  ex_data_pkg::xword_t  src2,
    input  ex_data_pkg::xword_t  pc,
    input  ex_data_pkg::imm_t    imm,
    input  ex_ctrl_pkg::a_sel_t  a_sel,
    input  ex_ctrl_pkg::b_sel_t  b_sel,
    input  ex_ctrl_pkg::alu_op_t alu_op,
    output ex_data_pkg::xword_t  alu_result,
    output logic                 zero
);
    import ex_data_pkg::*;
    import ex_ctrl_pkg::*;

    xword_t      imm_ext;
    xword_t      op_a;
    xword_t      op_b;
    logic [31:0] w_res;

    assign imm_ext = {{(`EX_XLEN - `EX_IMM_W){imm[`EX_IMM_W-1]}}, imm};
    assign op_a    = (a_sel == A_PC) ? pc : src1;

    always_comb begin
        case (b_sel)
            B_FOUR:  op_b = xword_t'(4);
            B_IMM:   op_b = imm_ext;
            default: op_b = src2;
        endcase
    end

    // word forms, 5-bit shift amount
    always_comb begin
        case (alu_op)
            ALU_SUBW: w_res = op_a[31:0] - op_b[31:0];
            ALU_SLLW: w_res = op_a[31:0] << op_b[4:0];
            ALU_SRLW: w_res = op_a[31:0] >> op_b[4:0];
            ALU_SRAW: w_res = $signed(op_a[31:0]) >>> op_b[4:0];
            default:  w_res = op_a[31:0] + op_b[31:0];
        endcase
    end

    always_comb begin
        case (alu_op)
            ALU_SUB:  alu_result = op_a - op_b;
            ALU_SLL:  alu_result = op_a << op_b[5:0];
            ALU_SLT:  alu_result = xword_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU: alu_result = xword_t'(op_a < op_b);
            ALU_XOR:  alu_result = op_a ^ op_b;
            ALU_SRL:  alu_result = op_a >> op_b[5:0];
            ALU_SRA:  alu_result = $signed(op_a) >>> op_b[5:0];
            ALU_OR:   alu_result = op_a | op_b;
            ALU_AND:  alu_result = op_a & op_b;
            ALU_ADDW, ALU_SUBW, ALU_SLLW, ALU_SRLW, ALU_SRAW:
                alu_result = {{32{w_res[31]}}, w_res};
            default:  alu_result = op_a + op_b;
        endcase
    end

    assign zero = (alu_result == '0);

endmodule

//--- hdl/ex_branch_unit.sv
`include "ex_consts.svh"

module ex_branch_unit (
    input  logic                iss_valid,
    input  ex_ctrl_pkg::br_op_t br_op,
    input  ex_data_pkg::xword_t pc,
    input  ex_data_pkg::xword_t src1,
    input  ex_data_pkg::imm_t   imm,
    input  logic                zero,
    input  logic                alu_lsb,
    output logic                is_jmp,
    output ex_data_pkg::xword_t nxtpc
);
    import ex_data_pkg::*;
    import ex_ctrl_pkg::*;

    xword_t imm_ext;
    logic   taken;

    assign imm_ext = {{(`EX_XLEN - `EX_IMM_W){imm[`EX_IMM_W-1]}}, imm};

    // alu runs SUB for eq/ne, SLT(U) for the ordered compares
    always_comb begin
        case (br_op)
            BR_JAL, BR_JALR:  taken = 1'b1;
            BR_BEQ:           taken = zero;
            BR_BNE:           taken = ~zero;
            BR_BLT, BR_BLTU:  taken = alu_lsb;
            BR_BGE, BR_BGEU:  taken = ~alu_lsb;
            default:          taken = 1'b0;
        endcase
    end

    always_comb begin
        if (br_op == BR_JALR) begin
            nxtpc = (src1 + imm_ext) & ~xword_t'(1);
        end else if (taken) begin
            nxtpc = pc + imm_ext;
        end else begin
            nxtpc = pc + xword_t'(4);
        end
    end

    assign is_jmp = iss_valid & taken;

endmodule

//--- hdl/ex_consts.svh
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

// data path width
`define EX_XLEN 64

// immediate as it leaves decode
`define EX_IMM_W 32

// register file index
`define EX_REG_W 5

// one multiplier bit per cycle
`define EX_MUL_STEPS 64

`endif

//--- hdl/ex_ctrl_pkg.sv
package ex_ctrl_pkg;

    typedef enum logic [4:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_ADDW,
        ALU_SUBW,
        ALU_SLLW,
        ALU_SRLW,
        ALU_SRAW
    } alu_op_t;

    typedef enum logic {
        A_RS1,
        A_PC
    } a_sel_t;

    typedef enum logic [1:0] {
        B_RS2,
        B_FOUR,
        B_IMM
    } b_sel_t;

    typedef enum logic [3:0] {
        BR_NONE,
        BR_JAL,
        BR_JALR,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU
    } br_op_t;

    typedef enum logic [1:0] {
        MUL_MUL,
        MUL_MULH,  // signed x signed, high word
        MUL_MULHU,
        MUL_MULW
    } mul_op_t;

    typedef enum logic [1:0] {
        MS_IDLE,
        MS_RUN,
        MS_DONE
    } mul_state_t;

endpackage

//--- hdl/ex_data_pkg.sv
`include "ex_consts.svh"

package ex_data_pkg;

    typedef logic [`EX_XLEN-1:0] xword_t;    // operands, results, pc
    typedef logic [`EX_IMM_W-1:0] imm_t;     // raw, sign-extended later
    typedef logic [`EX_REG_W-1:0] reg_idx_t; // destination index

endpackage

//--- hdl/ex_issue_reg.sv
module ex_issue_reg (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  flush,
    input  logic                  stall,
    input  logic                  in_valid,
    input  ex_data_pkg::xword_t   src1,
    input  ex_data_pkg::xword_t   src2,
    input  ex_data_pkg::imm_t     imm,
    input  ex_data_pkg::xword_t   pc,
    input  ex_data_pkg::reg_idx_t rd,
    input  logic                  reg_wr,
    input  ex_ctrl_pkg::a_sel_t   a_sel,
    input  ex_ctrl_pkg::b_sel_t   b_sel,
    input  ex_ctrl_pkg::alu_op_t  alu_op,
    input  ex_ctrl_pkg::br_op_t   br_op,
    input  logic                  is_mul,
    input  ex_ctrl_pkg::mul_op_t  mul_op,
    output logic                  in_ready,
    output logic                  iss_valid,
    output ex_data_pkg::xword_t   iss_src1,
    output ex_data_pkg::xword_t   iss_src2,
    output ex_data_pkg::imm_t     iss_imm,
    output ex_data_pkg::xword_t   iss_pc,
    output ex_data_pkg::reg_idx_t iss_rd,
    output logic                  iss_reg_wr,
    output ex_ctrl_pkg::a_sel_t   iss_a_sel,
    output ex_ctrl_pkg::b_sel_t   iss_b_sel,
    output ex_ctrl_pkg::alu_op_t  iss_alu_op,
    output ex_ctrl_pkg::br_op_t   iss_br_op,
    output logic                  iss_is_mul,
    output ex_ctrl_pkg::mul_op_t  iss_mul_op
);

    assign in_ready = ~stall; // empty slot still waits on the result stage

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            iss_valid <= 1'b0;
        end else if (flush) begin
            iss_valid <= 1'b0; // squash whatever sits here
        end else if (!stall) begin
            iss_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            iss_src1   <= src1;
            iss_src2   <= src2;
            iss_imm    <= imm;
            iss_pc     <= pc;
            iss_rd     <= rd;
            iss_reg_wr <= reg_wr;
            iss_a_sel  <= a_sel;
            iss_b_sel  <= b_sel;
            iss_alu_op <= alu_op;
            iss_br_op  <= br_op;
            iss_is_mul <= is_mul;
            iss_mul_op <= mul_op;
        end
    end

    // a stalled operation must not change under the multiplier or result stage
    a_hold_stable: assert property (@(posedge clk) disable iff (!arst_n)
        iss_valid && stall |=> $stable(iss_src1) && $stable(iss_src2) && $stable(iss_imm)
            && $stable(iss_pc) && $stable(iss_rd) && $stable(iss_alu_op)
            && $stable(iss_is_mul) && $stable(iss_mul_op) && $stable(iss_br_op));

endmodule

//--- hdl/ex_mul_unit.sv
`include "ex_consts.svh"

module ex_mul_unit (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 flush,
    input  logic                 mul_start,
    input  logic                 mul_ack,
    input  ex_data_pkg::xword_t  src1,
    input  ex_data_pkg::xword_t  src2,
    input  ex_ctrl_pkg::mul_op_t mul_op,
    output logic                 mul_done,
    output logic                 mul_busy,
    output ex_data_pkg::xword_t  mul_result
);
    import ex_data_pkg::*;
    import ex_ctrl_pkg::*;

    localparam int CNT_W = $clog2(`EX_MUL_STEPS);

    mul_state_t             state;
    logic [CNT_W-1:0]       cnt;
    logic [2*`EX_XLEN-1:0]  acc;
    logic [2*`EX_XLEN-1:0]  mcand;
    logic [2*`EX_XLEN-1:0]  prod;
    xword_t                 mplier;
    xword_t                 a_mag;
    xword_t                 b_mag;
    logic                   neg_a;
    logic                   neg_b;
    logic                   neg_q;
    mul_op_t                op_q;

    // only MULH needs signed magnitudes, low words come out right unsigned
    assign neg_a = (mul_op == MUL_MULH) & src1[`EX_XLEN-1];
    assign neg_b = (mul_op == MUL_MULH) & src2[`EX_XLEN-1];
    assign a_mag = neg_a ? -src1 : src1;
    assign b_mag = neg_b ? -src2 : src2;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= MS_IDLE;
            cnt   <= '0;
        end else if (flush) begin
            state <= MS_IDLE; // abort
            cnt   <= '0;
        end else begin
            case (state)
                MS_IDLE: begin
                    cnt <= '0;
                    if (mul_start) state <= MS_RUN;
                end
                MS_RUN: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(`EX_MUL_STEPS - 1)) state <= MS_DONE;
                end
                MS_DONE: begin
                    if (mul_ack) state <= MS_IDLE; // product taken
                end
                default: state <= MS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == MS_IDLE && mul_start) begin
            acc    <= '0;
            mcand  <= {{`EX_XLEN{1'b0}}, a_mag};
            mplier <= b_mag;
            neg_q  <= neg_a ^ neg_b;
            op_q   <= mul_op;
        end else if (state == MS_RUN) begin
            if (mplier[0]) acc <= acc + mcand;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign prod = neg_q ? -acc : acc;

    always_comb begin
        case (op_q)
            MUL_MULH, MUL_MULHU: mul_result = prod[2*`EX_XLEN-1:`EX_XLEN];
            MUL_MULW:            mul_result = {{32{prod[31]}}, prod[31:0]};
            default:             mul_result = prod[`EX_XLEN-1:0];
        endcase
    end

    assign mul_done = (state == MS_DONE);
    assign mul_busy = (state != MS_IDLE);

    // the stage must wait for the unit before starting another product
    a_start_idle: assert property (@(posedge clk) disable iff (!arst_n)
        mul_start |-> state == MS_IDLE);

    // done only after a full run of steps
    a_done_after_run: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(mul_done) |-> $past(state, `EX_MUL_STEPS) == MS_RUN
            && $past(state, `EX_MUL_STEPS + 1) == MS_IDLE);

endmodule

//--- hdl/ex_result_stage.sv
module ex_result_stage (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  flush,
    input  logic                  iss_valid,
    input  logic                  stall,
    input  logic                  is_mul,
    input  ex_data_pkg::xword_t   alu_result,
    input  ex_data_pkg::xword_t   mul_result,
    input  ex_data_pkg::reg_idx_t rd,
    input  logic                  reg_wr,
    input  logic                  is_jmp_in,
    input  ex_data_pkg::xword_t   nxtpc_in,
    input  logic                  out_ready,
    output logic                  out_valid,
    output ex_data_pkg::xword_t   result,
    output ex_data_pkg::reg_idx_t out_rd,
    output logic                  out_reg_wr,
    output logic                  is_jmp,
    output ex_data_pkg::xword_t   nxtpc,
    output logic                  res_full
);

    logic latch;

    assign res_full = out_valid & ~out_ready; // held result not yet taken
    assign latch    = iss_valid & ~stall;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            is_jmp    <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
            is_jmp    <= 1'b0;
        end else if (!res_full) begin
            out_valid <= latch;
            is_jmp    <= latch & is_jmp_in;
        end
    end

    always_ff @(posedge clk) begin
        if (latch) begin
            result     <= is_mul ? mul_result : alu_result;
            out_rd     <= rd;
            out_reg_wr <= reg_wr;
            nxtpc      <= nxtpc_in;
        end
    end

    a_out_stable: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready && !flush |=> out_valid && $stable(result)
            && $stable(out_rd) && $stable(out_reg_wr) && $stable(is_jmp) && $stable(nxtpc));

endmodule

//--- hdl/ex_stage.sv
module ex_stage (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  flush,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  ex_data_pkg::xword_t   src1,
    input  ex_data_pkg::xword_t   src2,
    input  ex_data_pkg::imm_t     imm,
    input  ex_data_pkg::xword_t   pc,
    input  ex_data_pkg::reg_idx_t rd,
    input  logic                  reg_wr,
    input  ex_ctrl_pkg::a_sel_t   a_sel,
    input  ex_ctrl_pkg::b_sel_t   b_sel,
    input  ex_ctrl_pkg::alu_op_t  alu_op,
    input  ex_ctrl_pkg::br_op_t   br_op,
    input  logic                  is_mul,
    input  ex_ctrl_pkg::mul_op_t  mul_op,
    output logic                  out_valid,
    input  logic                  out_ready,
    output ex_data_pkg::xword_t   result,
    output ex_data_pkg::reg_idx_t out_rd,
    output logic                  out_reg_wr,
    output logic                  is_jmp,
    output ex_data_pkg::xword_t   nxtpc
);
    import ex_data_pkg::*;
    import ex_ctrl_pkg::*;

    logic     stall;
    logic     iss_valid;
    xword_t   iss_src1;
    xword_t   iss_src2;
    imm_t     iss_imm;
    xword_t   iss_pc;
    reg_idx_t iss_rd;
    logic     iss_reg_wr;
    a_sel_t   iss_a_sel;
    b_sel_t   iss_b_sel;
    alu_op_t  iss_alu_op;
    br_op_t   iss_br_op;
    logic     iss_is_mul;
    mul_op_t  iss_mul_op;
    xword_t   alu_result;
    logic     zero;
    logic     br_jmp;
    xword_t   br_nxtpc;
    logic     mul_start;
    logic     mul_ack;
    logic     mul_done;
    logic     mul_busy;
    xword_t   mul_result;
    logic     res_full;

    assign stall     = res_full | (iss_valid & iss_is_mul & ~mul_done);
    assign mul_start = iss_valid & iss_is_mul & ~mul_busy;
    assign mul_ack   = iss_valid & iss_is_mul & ~stall; // result stage takes the product

    ex_issue_reg u_issue (
        .clk, .arst_n, .flush, .stall, .in_valid,
        .src1, .src2, .imm, .pc, .rd, .reg_wr,
        .a_sel, .b_sel, .alu_op, .br_op, .is_mul, .mul_op,
        .in_ready, .iss_valid,
        .iss_src1, .iss_src2, .iss_imm, .iss_pc, .iss_rd, .iss_reg_wr,
        .iss_a_sel, .iss_b_sel, .iss_alu_op, .iss_br_op, .iss_is_mul, .iss_mul_op
    );

    ex_alu u_alu (
        .src1(iss_src1), .src2(iss_src2), .pc(iss_pc), .imm(iss_imm),
        .a_sel(iss_a_sel), .b_sel(iss_b_sel), .alu_op(iss_alu_op),
        .alu_result, .zero
    );

    ex_branch_unit u_branch (
        .iss_valid, .br_op(iss_br_op), .pc(iss_pc), .src1(iss_src1), .imm(iss_imm),
        .zero, .alu_lsb(alu_result[0]),
        .is_jmp(br_jmp), .nxtpc(br_nxtpc)
    );

    ex_mul_unit u_mul (
        .clk, .arst_n, .flush, .mul_start, .mul_ack,
        .src1(iss_src1), .src2(iss_src2), .mul_op(iss_mul_op),
        .mul_done, .mul_busy, .mul_result
    );

    ex_result_stage u_result (
        .clk, .arst_n, .flush, .iss_valid, .stall, .is_mul(iss_is_mul),
        .alu_result, .mul_result, .rd(iss_rd), .reg_wr(iss_reg_wr),
        .is_jmp_in(br_jmp), .nxtpc_in(br_nxtpc), .out_ready,
        .out_valid, .result, .out_rd, .out_reg_wr, .is_jmp, .nxtpc, .res_full
    );

endmodule

//--- sim.f
+incdir+hdl
hdl/ex_data_pkg.sv
hdl/ex_ctrl_pkg.sv
hdl/ex_issue_reg.sv
hdl/ex_alu.sv
hdl/ex_branch_unit.sv
hdl/ex_mul_unit.sv
hdl/ex_result_stage.sv
hdl/ex_stage.sv
verif/ex_stage_tb.sv

//--- verif/ex_stage_tb.sv
`include "ex_consts.svh"

module ex_stage_tb;
    import ex_data_pkg::*;
    import ex_ctrl_pkg::*;

    localparam int MAX_OPS = 64;

    typedef struct packed {
        xword_t  src1;
        xword_t  src2;
        imm_t    imm;
        xword_t  pc;
        a_sel_t  a_sel;
        b_sel_t  b_sel;
        alu_op_t alu_op;
        br_op_t  br_op;
        logic    is_mul;
        mul_op_t mul_op;
        logic    bp;       // random out_ready stretches while this one runs
        logic    kill;     // flushed in flight, never seen at the output
        xword_t  res;
        logic    jmp;
        xword_t  nxt;
    } entry_t;

    logic     clk;
    logic     arst_n;
    logic     flush;
    logic     in_valid;
    logic     in_ready;
    xword_t   src1;
    xword_t   src2;
    imm_t     imm;
    xword_t   pc;
    reg_idx_t rd;
    logic     reg_wr;
    a_sel_t   a_sel;
    b_sel_t   b_sel;
    alu_op_t  alu_op;
    br_op_t   br_op;
    logic     is_mul;
    mul_op_t  mul_op;
    logic     out_valid;
    logic     out_ready;
    xword_t   result;
    reg_idx_t out_rd;
    logic     out_reg_wr;
    logic     is_jmp;
    xword_t   nxtpc;

    entry_t   tbl [MAX_OPS];
    string    t_name [MAX_OPS];
    int       exp_q [$];       // accepted entries in order
    int       n_ops;
    int       cur_idx;
    int       errors;
    int       tests_done;
    int       cycles;
    int       limit = 0;
    integer   seed;
    logic     bp_mode;
    logic     hold_low;

    ex_stage u_dut (
        .clk, .arst_n, .flush, .in_valid, .in_ready,
        .src1, .src2, .imm, .pc, .rd, .reg_wr,
        .a_sel, .b_sel, .alu_op, .br_op, .is_mul, .mul_op,
        .out_valid, .out_ready, .result, .out_rd, .out_reg_wr, .is_jmp, .nxtpc
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    function automatic xword_t rnd64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic xword_t sext(input imm_t im);
        return {{32{im[31]}}, im};
    endfunction

    function automatic xword_t ref_alu(input xword_t a, input xword_t b, input alu_op_t op);
        logic [31:0] w;
        int          sh;
        sh = b[5:0];
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLL:  return a << sh;
            ALU_SLT:  return (a[63] != b[63]) ? xword_t'(a[63]) : xword_t'(a < b);
            ALU_SLTU: return xword_t'(a < b);
            ALU_XOR:  return a ^ b;
            ALU_SRL:  return a >> sh;
            ALU_SRA:  return (a >> sh) | (a[63] ? ~({64{1'b1}} >> sh) : 64'h0);
            ALU_OR:   return a | b;
            ALU_AND:  return a & b;
            ALU_ADDW: w = a[31:0] + b[31:0];
            ALU_SUBW: w = a[31:0] - b[31:0];
            ALU_SLLW: w = a[31:0] << b[4:0];
            ALU_SRLW: w = a[31:0] >> b[4:0];
            default:  w = (a[31:0] >> b[4:0]) | (a[31] ? ~(32'hFFFF_FFFF >> b[4:0]) : 32'h0);
        endcase
        return {{32{w[31]}}, w};
    endfunction

    function automatic xword_t ref_mul(input xword_t a, input xword_t b, input mul_op_t op);
        logic signed [127:0] sp;
        logic [127:0]        up;
        logic [63:0]         wp;
        sp = $signed({{64{a[63]}}, a}) * $signed({{64{b[63]}}, b});
        up = {64'h0, a} * {64'h0, b};
        wp = {32'h0, a[31:0]} * {32'h0, b[31:0]};
        case (op)
            MUL_MULH:  return sp[127:64];
            MUL_MULHU: return up[127:64];
            MUL_MULW:  return {{32{wp[31]}}, wp[31:0]};
            default:   return up[63:0];
        endcase
    endfunction

    function automatic logic ref_taken(input br_op_t br, input xword_t a, input xword_t b);
        case (br)
            BR_JAL, BR_JALR: return 1'b1;
            BR_BEQ:  return a == b;
            BR_BNE:  return a != b;
            BR_BLT:  return $signed(a) < $signed(b);
            BR_BGE:  return !($signed(a) < $signed(b));
            BR_BLTU: return a < b;
            BR_BGEU: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic xword_t ref_nxtpc(input br_op_t br, input logic taken, input xword_t p,
                                         input xword_t a, input imm_t im);
        xword_t t;
        t = a + sext(im);
        if (br == BR_JALR) return {t[63:1], 1'b0};
        if (taken) return p + sext(im);
        return p + 64'd4;
    endfunction

    task automatic add_op(input string name, input xword_t s1, input xword_t s2, input imm_t im,
                          input a_sel_t as, input b_sel_t bs, input alu_op_t op,
                          input br_op_t br, input logic mul, input mul_op_t mop,
                          input logic bp, input logic kill);
        entry_t e;
        xword_t opa;
        xword_t opb;
        e.src1   = s1;
        e.src2   = s2;
        e.imm    = im;
        e.pc     = 64'h0000_0000_8000_0000 + xword_t'(n_ops * 4);
        e.a_sel  = as;
        e.b_sel  = bs;
        e.alu_op = op;
        e.br_op  = br;
        e.is_mul = mul;
        e.mul_op = mop;
        e.bp     = bp;
        e.kill   = kill;
        opa = (as == A_PC) ? e.pc : s1;
        case (bs)
            B_FOUR:  opb = 64'd4;
            B_IMM:   opb = sext(im);
            default: opb = s2;
        endcase
        e.res = mul ? ref_mul(s1, s2, mop) : ref_alu(opa, opb, op);
        e.jmp = ref_taken(br, s1, s2);
        e.nxt = ref_nxtpc(br, e.jmp, e.pc, s1, im);
        tbl[n_ops]    = e;
        t_name[n_ops] = name;
        n_ops++;
    endtask

    task automatic add_rr(input string name, input xword_t a, input xword_t b,
                          input alu_op_t op, input logic bp);
        add_op(name, a, b, '0, A_RS1, B_RS2, op, BR_NONE, 1'b0, MUL_MUL, bp, 1'b0);
    endtask

    task automatic add_ri(input string name, input xword_t a, input imm_t im, input alu_op_t op);
        add_op(name, a, '0, im, A_RS1, B_IMM, op, BR_NONE, 1'b0, MUL_MUL, 1'b0, 1'b0);
    endtask

    task automatic add_branch(input string name, input br_op_t br, input alu_op_t op,
                              input xword_t a, input xword_t b, input imm_t im);
        if (br == BR_JAL || br == BR_JALR) begin
            add_op(name, a, b, im, A_PC, B_FOUR, ALU_ADD, br, 1'b0, MUL_MUL, 1'b0, 1'b0);
        end else begin
            add_op(name, a, b, im, A_RS1, B_RS2, op, br, 1'b0, MUL_MUL, 1'b0, 1'b0);
        end
    endtask

    task automatic add_mul(input string name, input xword_t a, input xword_t b,
                           input mul_op_t mop, input logic bp, input logic kill);
        add_op(name, a, b, '0, A_RS1, B_RS2, ALU_ADD, BR_NONE, 1'b1, mop, bp, kill);
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    // result held (or product running) when flush hits
    task automatic flush_in_flight(input int i);
        int waited;
        int e0;
        waited = 0;
        e0     = errors;
        while (!out_valid && waited < 12) begin
            @(negedge clk);
            waited++;
        end
        @(posedge clk);
        #1;
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush    = 1'b0;
        hold_low = 1'b0;
        @(negedge clk);
        check_value(out_valid, 1'b0, "out_valid after flush");
        check_value(is_jmp, 1'b0, "is_jmp after flush");
        check_value(in_ready, 1'b1, "in_ready after flush");
        $display("test %0d %s: %s", i, t_name[i], (errors == e0) ? "ok" : "failed");
        tests_done++;
        @(posedge clk);
        #1;
    endtask

    task automatic apply_entry(input int i);
        if (tbl[i].kill) wait_drain();
        src1     = tbl[i].src1;
        src2     = tbl[i].src2;
        imm      = tbl[i].imm;
        pc       = tbl[i].pc;
        rd       = reg_idx_t'(i);
        reg_wr   = ((i % 3) != 0);
        a_sel    = tbl[i].a_sel;
        b_sel    = tbl[i].b_sel;
        alu_op   = tbl[i].alu_op;
        br_op    = tbl[i].br_op;
        is_mul   = tbl[i].is_mul;
        mul_op   = tbl[i].mul_op;
        cur_idx  = i;
        bp_mode  = tbl[i].bp;
        hold_low = tbl[i].kill;
        in_valid = 1'b1;
        @(negedge clk);
        while (!in_ready) @(negedge clk);
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        if (tbl[i].kill) flush_in_flight(i);
    endtask

    // out_ready decided at negedge, driven after the next rising edge
    initial begin
        logic nxt;
        forever begin
            @(negedge clk);
            if (hold_low) nxt = 1'b0;
            else if (bp_mode) nxt = (($random(seed) & 3) == 0);
            else nxt = 1'b1;
            @(posedge clk);
            #1;
            out_ready = nxt;
        end
    end

    initial begin
        int idx;
        int e0;
        forever begin
            @(negedge clk);
            if (arst_n) begin
                if (out_valid && !out_ready)
                    check_value(in_ready, 1'b0, "in_ready while a result is held");
                if (out_valid && out_ready) begin
                    if (exp_q.size() == 0) begin
                        $display("output transfer at %0t with no operation pending", $time);
                        errors++;
                    end else begin
                        idx = exp_q.pop_front();
                        e0  = errors;
                        check_value(result, tbl[idx].res, {t_name[idx], " result"});
                        check_value(is_jmp, tbl[idx].jmp, {t_name[idx], " is_jmp"});
                        check_value(nxtpc, tbl[idx].nxt, {t_name[idx], " nxtpc"});
                        check_value(out_rd, reg_idx_t'(idx), {t_name[idx], " rd"});
                        check_value(out_reg_wr, (idx % 3) != 0, {t_name[idx], " reg_wr"});
                        $display("test %0d %s: %s", idx, t_name[idx],
                                 (errors == e0) ? "ok" : "failed");
                        tests_done++;
                    end
                end
                if (in_valid && in_ready && !tbl[cur_idx].kill) exp_q.push_back(cur_idx);
            end
        end
    end

    initial begin
        wait (limit > 0);
        cycles = 0;
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("run timed out after %0d cycles", cycles);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        xword_t r;
        int     e0;
        seed       = 99;
        arst_n     = 1'b0;
        flush      = 1'b0;
        in_valid   = 1'b0;
        src1       = '0;
        src2       = '0;
        imm        = '0;
        pc         = '0;
        rd         = '0;
        reg_wr     = 1'b0;
        a_sel      = A_RS1;
        b_sel      = B_RS2;
        alu_op     = ALU_ADD;
        br_op      = BR_NONE;
        is_mul     = 1'b0;
        mul_op     = MUL_MUL;
        out_ready  = 1'b1;
        bp_mode    = 1'b0;
        hold_low   = 1'b0;
        errors     = 0;
        tests_done = 0;
        n_ops      = 0;
        cur_idx    = 0;

        add_rr("add", rnd64(), rnd64(), ALU_ADD, 1'b0);
        add_rr("sub", rnd64(), rnd64(), ALU_SUB, 1'b0);
        add_rr("sll", rnd64(), rnd64(), ALU_SLL, 1'b0);
        add_rr("slt", rnd64(), rnd64(), ALU_SLT, 1'b0);
        add_rr("slt neg", 64'hFFFF_FFFF_FFFF_FFFB, 64'd3, ALU_SLT, 1'b0);
        add_rr("sltu neg", 64'hFFFF_FFFF_FFFF_FFFB, 64'd3, ALU_SLTU, 1'b0);
        add_rr("xor", rnd64(), rnd64(), ALU_XOR, 1'b0);
        add_rr("srl", rnd64(), rnd64(), ALU_SRL, 1'b0);
        add_rr("sra", 64'hF000_0000_0000_1234, rnd64(), ALU_SRA, 1'b0);
        add_rr("or", rnd64(), rnd64(), ALU_OR, 1'b0);
        add_rr("and", rnd64(), rnd64(), ALU_AND, 1'b0);
        add_rr("addw", rnd64(), rnd64(), ALU_ADDW, 1'b0);
        add_rr("subw", rnd64(), rnd64(), ALU_SUBW, 1'b0);
        add_rr("sllw", rnd64(), rnd64(), ALU_SLLW, 1'b0);
        add_rr("srlw", rnd64(), rnd64(), ALU_SRLW, 1'b0);
        add_rr("sraw", 64'h0000_0000_8000_00F0, 64'd4, ALU_SRAW, 1'b0);
        add_ri("addi neg", rnd64(), 32'hFFFF_FFFB, ALU_ADD);
        add_ri("srai 63", 64'h8000_0000_0000_0000, 32'd63, ALU_SRA);
        add_ri("slliw 31", rnd64(), 32'd31, ALU_SLLW);
        add_op("auipc", '0, '0, 32'h0001_2000, A_PC, B_IMM, ALU_ADD, BR_NONE,
               1'b0, MUL_MUL, 1'b0, 1'b0);

        r = rnd64();
        add_branch("beq taken", BR_BEQ, ALU_SUB, r, r, 32'h40);
        add_branch("beq not", BR_BEQ, ALU_SUB, r, r + 1, 32'h40);
        add_branch("bne taken", BR_BNE, ALU_SUB, r, r + 1, 32'hFFFF_FFF0);
        add_branch("bne not", BR_BNE, ALU_SUB, r, r, 32'hFFFF_FFF0);
        add_branch("blt taken", BR_BLT, ALU_SLT, 64'hFFFF_FFFF_FFFF_FFF0, 64'd5, 32'h40);
        add_branch("blt not", BR_BLT, ALU_SLT, 64'd5, 64'hFFFF_FFFF_FFFF_FFF0, 32'h40);
        add_branch("bge taken", BR_BGE, ALU_SLT, r, r, 32'h80);
        add_branch("bge not", BR_BGE, ALU_SLT, 64'hFFFF_FFFF_FFFF_FFF0, 64'd5, 32'h80);
        add_branch("bltu taken", BR_BLTU, ALU_SLTU, 64'd5, 64'hFFFF_FFFF_FFFF_FFF0, 32'h40);
        add_branch("bltu not", BR_BLTU, ALU_SLTU, 64'hFFFF_FFFF_FFFF_FFF0, 64'd5, 32'h40);
        add_branch("bgeu taken", BR_BGEU, ALU_SLTU, 64'hFFFF_FFFF_FFFF_FFF0, 64'd5, 32'h40);
        add_branch("bgeu not", BR_BGEU, ALU_SLTU, 64'd5, 64'hFFFF_FFFF_FFFF_FFF0, 32'h40);
        add_branch("jal", BR_JAL, ALU_ADD, '0, '0, 32'hFFFF_FFF0);
        add_branch("jalr odd", BR_JALR, ALU_ADD, 64'h0000_0000_8000_1001, '0, 32'h20);

        add_mul("mul", rnd64(), rnd64(), MUL_MUL, 1'b0, 1'b0);
        add_mul("mulh", rnd64(), rnd64(), MUL_MULH, 1'b0, 1'b0);
        add_mul("mulh min min", 64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000,
                MUL_MULH, 1'b0, 1'b0);
        add_mul("mulh neg pos", 64'hFFFF_FFFF_FFFF_FFFD, 64'd7, MUL_MULH, 1'b0, 1'b0);
        add_mul("mulhu ones", '1, '1, MUL_MULHU, 1'b0, 1'b0);
        add_mul("mulw neg", 64'h1234_5678_8000_0003, rnd64(), MUL_MULW, 1'b0, 1'b0);
        add_mul("mul zero", '0, rnd64(), MUL_MUL, 1'b0, 1'b0);
        add_rr("add behind mul", rnd64(), rnd64(), ALU_ADD, 1'b0);

        add_rr("bp add", rnd64(), rnd64(), ALU_ADD, 1'b1);
        add_mul("bp mul", rnd64(), rnd64(), MUL_MUL, 1'b1, 1'b0);
        add_rr("bp xor", rnd64(), rnd64(), ALU_XOR, 1'b1);
        add_rr("bp sub", rnd64(), rnd64(), ALU_SUB, 1'b1);
        add_mul("bp mulhu", rnd64(), rnd64(), MUL_MULHU, 1'b1, 1'b0);
        add_rr("bp or", rnd64(), rnd64(), ALU_OR, 1'b1);
        add_rr("bp and", rnd64(), rnd64(), ALU_AND, 1'b1);

        add_mul("flush mul", rnd64(), rnd64(), MUL_MULH, 1'b0, 1'b1);
        add_mul("mul after flush", rnd64(), rnd64(), MUL_MULH, 1'b0, 1'b0);
        add_op("flush held add", rnd64(), rnd64(), '0, A_RS1, B_RS2, ALU_ADD, BR_NONE,
               1'b0, MUL_MUL, 1'b0, 1'b1);
        add_rr("add after flush", rnd64(), rnd64(), ALU_ADD, 1'b0);

        limit = n_ops * (`EX_MUL_STEPS + 10) + 5;

        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(negedge clk);
        e0 = errors;
        check_value(out_valid, 1'b0, "out_valid after reset");
        check_value(is_jmp, 1'b0, "is_jmp after reset");
        check_value(in_ready, 1'b1, "in_ready after reset");
        $display("test reset: %s", (errors == e0) ? "ok" : "failed");
        tests_done++;
        @(posedge clk);
        #1;

        for (int i = 0; i < n_ops; i++) apply_entry(i);
        wait_drain();
        repeat (4) @(posedge clk);

        $display("%0d of %0d tests completed, %0d errors", tests_done, n_ops + 1, errors);
        if (errors == 0 && tests_done == n_ops + 1) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
